// File: rv64_exu.f
design/rv64_exu_pkg.sv
design/alu_req_if.sv
design/exu_decoder.sv
design/rv64_alu.sv
design/exu_writeback.sv
design/rv64_exu.sv
testbench/exu_checker.sv
testbench/rv64_exu_tb.sv

// File: run_sim.sh
#!/bin/bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f rv64_exu.f --top-module rv64_exu_tb -o sim_rv64_exu
./obj_dir/sim_rv64_exu | tee sim.log

if grep -q "Simulation failed" sim.log; then
	echo "run failed"
	exit 1
fi
echo "run passed"

// File: testbench/rv64_exu_tb.sv
// execute stage testbench
`timescale 1ns/1ps

module rv64_exu_tb;

	localparam int XLEN = rv64_exu_pkg::XLEN;

	typedef struct {
		logic [8*16-1:0] name;
		logic [31:0]     instr;
		logic [XLEN-1:0] pc;
		logic [XLEN-1:0] rs1;
		logic [XLEN-1:0] rs2;
		bit              rnd;   // operands drawn at run time
		bit              vld;
		logic [XLEN-1:0] res;
		logic [4:0]      rd;
	} test_t;

	logic clk, rst, in_valid, out_valid;
	logic [31:0] in_instr;
	logic [XLEN-1:0] in_pc, in_rs1, in_rs2, out_result;
	logic [4:0] out_rd;
	logic exp_active, exp_valid;
	logic [XLEN-1:0] exp_result;
	logic [4:0] exp_rd;
	logic [8*16-1:0] exp_name;
	int done_count, fail_count;
	test_t tests[$];

	rv64_exu rv64_exu_i (.clk(clk), .rst(rst), .in_valid(in_valid), .in_instr(in_instr),
		.in_pc(in_pc), .in_rs1(in_rs1), .in_rs2(in_rs2), .out_valid(out_valid),
		.out_result(out_result), .out_rd(out_rd));

	exu_checker checker_i (.clk(clk), .rst(rst), .out_valid(out_valid),
		.out_result(out_result), .out_rd(out_rd), .exp_active(exp_active),
		.exp_valid(exp_valid), .exp_result(exp_result), .exp_rd(exp_rd),
		.exp_name(exp_name), .done_count(done_count), .fail_count(fail_count));

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	function automatic logic [31:0] r_type(logic [6:0] f7, logic [2:0] f3, logic [6:0] opc);
		return {f7, 5'd2, 5'd1, f3, 5'd0, opc}; // rd filled in later
	endfunction

	function automatic logic [31:0] i_type(logic [11:0] imm, logic [2:0] f3, logic [6:0] opc);
		return {imm, 5'd1, f3, 5'd0, opc};
	endfunction

	// reference for the register-register group used with random operands
	function automatic logic [XLEN-1:0] ref_result(logic [31:0] instr, logic [XLEN-1:0] a,
		logic [XLEN-1:0] b);
		if (instr[31:25] == 7'b0000001) begin
			case (instr[14:12])
				3'b000:  return a * b;
				3'b101:  return (b == 0) ? {XLEN{1'b1}} : a / b;
				default: return (b == 0) ? a : a % b;
			endcase
		end
		case (instr[14:12])
			3'b000:  return instr[30] ? a - b : a + b;
			3'b100:  return a ^ b;
			3'b110:  return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic add_test(logic [8*16-1:0] name, logic [31:0] instr, logic [XLEN-1:0] pc,
		logic [XLEN-1:0] rs1, logic [XLEN-1:0] rs2, bit rnd, bit vld, logic [XLEN-1:0] res);
		test_t t;
		t.rd = 5'((tests.size() % 31) + 1); // distinct rd on neighbouring tests
		t.name = name;
		t.instr = instr | {20'b0, t.rd, 7'b0};
		t.pc = pc;
		t.rs1 = rs1;
		t.rs2 = rs2;
		t.rnd = rnd;
		t.vld = vld;
		t.res = res;
		tests.push_back(t);
	endtask

	task automatic build_table();
		logic [6:0] op, opi, op32;
		logic [XLEN-1:0] sh;
		op = rv64_exu_pkg::OPC_OP;
		opi = rv64_exu_pkg::OPC_OP_IMM;
		op32 = rv64_exu_pkg::OPC_OP_32;
		sh = 64'h8000_0000_0000_0001;
		add_test("add_rnd", r_type(7'h00, 3'b000, op), 0, 0, 0, 1, 1, 0);
		add_test("sub_rnd", r_type(7'h20, 3'b000, op), 0, 0, 0, 1, 1, 0);
		add_test("and_rnd", r_type(7'h00, 3'b111, op), 0, 0, 0, 1, 1, 0);
		add_test("or_rnd", r_type(7'h00, 3'b110, op), 0, 0, 0, 1, 1, 0);
		add_test("xor_rnd", r_type(7'h00, 3'b100, op), 0, 0, 0, 1, 1, 0);
		add_test("sub_wrap", r_type(7'h20, 3'b000, op), 0, 0, 1, 0, 1, '1);
		add_test("slt_neg", r_type(7'h00, 3'b010, op), 0, '1, 1, 0, 1, 1);
		add_test("sltu_neg", r_type(7'h00, 3'b011, op), 0, '1, 1, 0, 1, 0);
		add_test("slli_0", i_type(12'h000, 3'b001, opi), 0, sh, 0, 0, 1, sh);
		add_test("slli_1", i_type(12'h001, 3'b001, opi), 0, sh, 0, 0, 1, 64'h2);
		add_test("slli_63", i_type(12'h03f, 3'b001, opi), 0, sh, 0, 0, 1, 64'h8000_0000_0000_0000);
		add_test("srli_0", i_type(12'h000, 3'b101, opi), 0, sh, 0, 0, 1, sh);
		add_test("srli_1", i_type(12'h001, 3'b101, opi), 0, sh, 0, 0, 1, 64'h4000_0000_0000_0000);
		add_test("srli_63", i_type(12'h03f, 3'b101, opi), 0, sh, 0, 0, 1, 1);
		add_test("srai_0", i_type(12'h400, 3'b101, opi), 0, sh, 0, 0, 1, sh);
		add_test("srai_1", i_type(12'h401, 3'b101, opi), 0, sh, 0, 0, 1, 64'hc000_0000_0000_0000);
		add_test("srai_63", i_type(12'h43f, 3'b101, opi), 0, sh, 0, 0, 1, '1);
		add_test("addi_neg", i_type(12'hffb, 3'b000, opi), 0, 100, 0, 0, 1, 95);
		add_test("lui_neg", {20'h80000, 5'd0, rv64_exu_pkg::OPC_LUI}, 0, 0, 0, 0, 1,
			64'hffff_ffff_8000_0000);
		add_test("auipc_neg", {20'hfffff, 5'd0, rv64_exu_pkg::OPC_AUIPC}, 64'h1_2344, 0, 0, 0, 1,
			64'h1_1344);
		add_test("addw_ovf", r_type(7'h00, 3'b000, op32), 0, 64'h7fff_ffff, 1, 0, 1,
			64'hffff_ffff_8000_0000);
		add_test("sraw_neg", r_type(7'h20, 3'b101, op32), 0, 64'hdead_beef_8000_0010, 36, 0, 1,
			64'hffff_ffff_f800_0001);
		add_test("srlw_neg", r_type(7'h00, 3'b101, op32), 0, 64'hdead_beef_8000_0010, 36, 0, 1,
			64'h0800_0001);
		add_test("mul_rnd", r_type(7'h01, 3'b000, op), 0, 0, 0, 1, 1, 0);
		add_test("divu_rnd", r_type(7'h01, 3'b101, op), 0, 0, 0, 1, 1, 0);
		add_test("remu_rnd", r_type(7'h01, 3'b111, op), 0, 0, 0, 1, 1, 0);
		add_test("divu_zero", r_type(7'h01, 3'b101, op), 0, 64'h1234, 0, 0, 1, '1);
		add_test("remu_zero", r_type(7'h01, 3'b111, op), 0, 64'h1234, 0, 0, 1, 64'h1234);
		add_test("load_unsup", i_type(12'h000, 3'b011, 7'b0000011), 0, 0, 0, 0, 0, 0);
	endtask

	initial begin
		test_t t;
		void'($urandom(32'h51de_e9fd));
		rst = 1'b1;
		in_valid = 1'b1; // legal add held during reset
		in_instr = r_type(7'h00, 3'b000, rv64_exu_pkg::OPC_OP);
		in_pc = '0;
		in_rs1 = '0;
		in_rs2 = '0;
		exp_active = 1'b0;
		exp_valid = 1'b0;
		exp_result = '0;
		exp_rd = '0;
		exp_name = '0;
		build_table();
		foreach (tests[i]) begin
			t = tests[i];
			if (t.rnd) begin
				t.rs1 = {$urandom, $urandom};
				t.rs2 = {$urandom, $urandom} >> ($urandom % 64); // keep some quotients large
				t.res = ref_result(t.instr, t.rs1, t.rs2);
				tests[i] = t;
			end
		end
		repeat (10) @(posedge clk);
		rst <= 1'b0;
		in_valid <= 1'b0;
		foreach (tests[i]) begin
			@(posedge clk);
			in_valid <= 1'b1;
			in_instr <= tests[i].instr;
			in_pc <= tests[i].pc;
			in_rs1 <= tests[i].rs1;
			in_rs2 <= tests[i].rs2;
			exp_active <= 1'b1;
			exp_valid <= tests[i].vld;
			exp_result <= tests[i].res;
			exp_rd <= tests[i].rd;
			exp_name <= tests[i].name;
		end
		@(posedge clk);
		in_valid <= 1'b0;
		exp_active <= 1'b0;
		while (done_count < tests.size())
			@(posedge clk);
		repeat (2) @(posedge clk); // catch stray strobes
		$display("tests run %0d, failures %0d", done_count, fail_count);
		if (fail_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	initial begin
		#1;
		#((tests.size() + 20) * 4 + 10 * 4);
		$display("timeout, the tests did not finish in time");
		$display("Simulation failed");
		$finish;
	end

endmodule

// File: testbench/exu_checker.sv
// execute stage result checker
`timescale 1ns/1ps

module exu_checker (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          out_valid,
	input  logic [rv64_exu_pkg::XLEN-1:0] out_result,
	input  logic [4:0]                    out_rd,
	input  logic                          exp_active, // an expectation is issued this cycle
	input  logic                          exp_valid,
	input  logic [rv64_exu_pkg::XLEN-1:0] exp_result,
	input  logic [4:0]                    exp_rd,
	input  logic [8*16-1:0]               exp_name,
	output int                            done_count,
	output int                            fail_count
);

	logic                          pend_active;
	logic                          pend_valid;
	logic [rv64_exu_pkg::XLEN-1:0] pend_result;
	logic [4:0]                    pend_rd;
	logic [8*16-1:0]               pend_name;

	initial begin
		pend_active = 1'b0;
		done_count  = 0;
		fail_count  = 0;
	end

	// expectation taken with the DUT inputs, output compared one edge later
	always @(posedge clk) begin
		if (rst && out_valid === 1'b1) begin
			$display("out_valid went high while reset was asserted");
			fail_count <= fail_count + 1;
		end else if (pend_active) begin
			done_count <= done_count + 1;
			if (pend_valid) begin
				if (out_valid !== 1'b1) begin
					$display("%s: no result strobe arrived", pend_name);
					fail_count <= fail_count + 1;
				end else if (out_result !== pend_result || out_rd !== pend_rd) begin
					$display("[FAIL] %s expected %h rd %0d actual %h rd %0d", pend_name,
						pend_result, pend_rd, out_result, out_rd);
					fail_count <= fail_count + 1;
				end else begin
					$display("[PASS] %s", pend_name);
				end
			end else if (out_valid !== 1'b0) begin
				$display("%s: result strobe for an instruction that should be dropped",
					pend_name);
				fail_count <= fail_count + 1;
			end else begin
				$display("[PASS] %s", pend_name);
			end
		end else if (!rst && out_valid === 1'b1) begin
			$display("result strobe with no instruction issued");
			fail_count <= fail_count + 1;
		end
		pend_active <= exp_active;
		pend_valid  <= exp_valid;
		pend_result <= exp_result;
		pend_rd     <= exp_rd;
		pend_name   <= exp_name;
	end

endmodule

// File: design/rv64_exu.sv
// RV64 integer execute stage
`timescale 1ns/1ps

module rv64_exu (
	input  logic                          clk,
	input  logic                          rst,
	input  logic                          in_valid,
	input  logic [31:0]                   in_instr,
	input  logic [rv64_exu_pkg::XLEN-1:0] in_pc,
	input  logic [rv64_exu_pkg::XLEN-1:0] in_rs1,
	input  logic [rv64_exu_pkg::XLEN-1:0] in_rs2,
	output logic                          out_valid,
	output logic [rv64_exu_pkg::XLEN-1:0] out_result,
	output logic [4:0]                    out_rd
);

	alu_req_if req_if ();

	logic [rv64_exu_pkg::XLEN-1:0] alu_result;

	exu_decoder decoder_i (
		.in_valid (in_valid),
		.in_instr (in_instr),
		.in_pc    (in_pc),
		.in_rs1   (in_rs1),
		.in_rs2   (in_rs2),
		.req      (req_if.producer)
	);

	// combinational, result lands in the writeback register
	rv64_alu alu_i (
		.alu_control (req_if.alu_control),
		.src1        (req_if.src1),
		.src2        (req_if.src2),
		.alu_result  (alu_result)
	);

	exu_writeback writeback_i (
		.clk        (clk),
		.rst        (rst),
		.req        (req_if.consumer),
		.alu_result (alu_result),
		.out_valid  (out_valid),
		.out_result (out_result),
		.out_rd     (out_rd)
	);

endmodule

// File: design/exu_writeback.sv
// result register
`timescale 1ns/1ps

module exu_writeback (
	input  logic                          clk,
	input  logic                          rst,
	alu_req_if.consumer                   req,
	input  logic [rv64_exu_pkg::XLEN-1:0] alu_result,
	output logic                          out_valid,
	output logic [rv64_exu_pkg::XLEN-1:0] out_result,
	output logic [4:0]                    out_rd
);

	localparam int XLEN = rv64_exu_pkg::XLEN;

	logic [XLEN-1:0] result_ext;

	// W forms keep the low word, sign-extended
	assign result_ext = req.word_op ?
		{{(XLEN-32){alu_result[31]}}, alu_result[31:0]} : alu_result;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid  <= 1'b0;
			out_result <= '0;
			out_rd     <= '0;
		end else begin
			out_valid  <= req.valid;
			out_result <= result_ext;
			out_rd     <= req.rd;
		end
	end

endmodule

// File: design/rv64_alu.sv
// 64-bit ALU
`timescale 1ns/1ps

module rv64_alu (
	input  logic [rv64_exu_pkg::ALU_OPS-1:0] alu_control,
	input  logic [rv64_exu_pkg::XLEN-1:0]    src1,
	input  logic [rv64_exu_pkg::XLEN-1:0]    src2,
	output logic [rv64_exu_pkg::XLEN-1:0]    alu_result
);

	localparam int XLEN = rv64_exu_pkg::XLEN;

	logic op_add;
	logic op_sub;
	logic op_slt;
	logic op_sltu;
	logic op_and;
	logic op_or;
	logic op_xor;
	logic op_sll;
	logic op_srl;
	logic op_sra;
	logic op_lui;
	logic op_mul;
	logic op_div;
	logic op_rem;

	assign op_add  = alu_control[rv64_exu_pkg::OP_ADD];
	assign op_sub  = alu_control[rv64_exu_pkg::OP_SUB];
	assign op_slt  = alu_control[rv64_exu_pkg::OP_SLT];
	assign op_sltu = alu_control[rv64_exu_pkg::OP_SLTU];
	assign op_and  = alu_control[rv64_exu_pkg::OP_AND];
	assign op_or   = alu_control[rv64_exu_pkg::OP_OR];
	assign op_xor  = alu_control[rv64_exu_pkg::OP_XOR];
	assign op_sll  = alu_control[rv64_exu_pkg::OP_SLL];
	assign op_srl  = alu_control[rv64_exu_pkg::OP_SRL];
	assign op_sra  = alu_control[rv64_exu_pkg::OP_SRA];
	assign op_lui  = alu_control[rv64_exu_pkg::OP_LUI];
	assign op_mul  = alu_control[rv64_exu_pkg::OP_MUL];
	assign op_div  = alu_control[rv64_exu_pkg::OP_DIV];
	assign op_rem  = alu_control[rv64_exu_pkg::OP_REM];

	logic            invert_b; // subtract for sub and both compares
	logic [XLEN-1:0] adder_b;
	logic [XLEN-1:0] adder_result;
	logic            adder_cout;
	logic [XLEN-1:0] slt_result;
	logic [XLEN-1:0] sltu_result;
	logic [XLEN-1:0] sll_result;
	logic [XLEN-1:0] srl_result;
	logic [XLEN-1:0] sra_result;
	logic [XLEN-1:0] mul_result;
	logic [XLEN-1:0] div_result;
	logic [XLEN-1:0] rem_result;
	logic            div_zero;

	assign invert_b = op_sub | op_slt | op_sltu;
	assign adder_b  = invert_b ? ~src2 : src2;
	assign {adder_cout, adder_result} = {1'b0, src1} + {1'b0, adder_b}
		+ {{XLEN{1'b0}}, invert_b};

	// negative vs positive decides directly, same signs look at the difference
	assign slt_result = {{(XLEN-1){1'b0}},
		(src1[XLEN-1] & ~src2[XLEN-1])
		| (~(src1[XLEN-1] ^ src2[XLEN-1]) & adder_result[XLEN-1])};
	assign sltu_result = {{(XLEN-1){1'b0}}, ~adder_cout}; // borrow

	assign sll_result = src1 << src2[5:0];
	assign srl_result = src1 >> src2[5:0];
	assign sra_result = $signed(src1) >>> src2[5:0];

	assign mul_result = src1 * src2;

	assign div_zero   = (src2 == '0);
	assign div_result = div_zero ? '1 : src1 / src2;
	assign rem_result = div_zero ? src1 : src1 % src2;

	assign alu_result = ({XLEN{op_add | op_sub}} & adder_result)
		| ({XLEN{op_slt}}  & slt_result)
		| ({XLEN{op_sltu}} & sltu_result)
		| ({XLEN{op_and}}  & (src1 & src2))
		| ({XLEN{op_or}}   & (src1 | src2))
		| ({XLEN{op_xor}}  & (src1 ^ src2))
		| ({XLEN{op_sll}}  & sll_result)
		| ({XLEN{op_srl}}  & srl_result)
		| ({XLEN{op_sra}}  & sra_result)
		| ({XLEN{op_lui}}  & src2)     // immediate already shifted and extended
		| ({XLEN{op_mul}}  & mul_result)
		| ({XLEN{op_div}}  & div_result)
		| ({XLEN{op_rem}}  & rem_result);

endmodule

// File: design/exu_decoder.sv
// instruction decode and operand select
`timescale 1ns/1ps

module exu_decoder (
	input  logic                          in_valid,
	input  logic [31:0]                   in_instr,
	input  logic [rv64_exu_pkg::XLEN-1:0] in_pc,
	input  logic [rv64_exu_pkg::XLEN-1:0] in_rs1,
	input  logic [rv64_exu_pkg::XLEN-1:0] in_rs2,
	alu_req_if.producer                   req
);

	localparam int XLEN = rv64_exu_pkg::XLEN;

	rv64_exu_pkg::rv64_instr_u instr;

	logic [rv64_exu_pkg::ALU_OPS-1:0] op;
	logic            legal;
	logic            word;
	logic            sel_imm;  // src2 from immediate
	logic            sel_u;    // U-type immediate
	logic            sel_pc;   // src1 from pc
	logic            src1_zx;
	logic            src1_sx;
	logic            shamt5;   // word shift, 5-bit amount
	logic [XLEN-1:0] imm_i;
	logic [XLEN-1:0] imm_u;
	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;

	assign instr = in_instr;

	assign imm_i = {{(XLEN-12){instr.i_fmt.imm12[11]}}, instr.i_fmt.imm12};
	assign imm_u = {{(XLEN-32){instr.i_fmt.imm12[11]}},
		instr.i_fmt.imm12, instr.i_fmt.rs1, instr.i_fmt.funct3, 12'b0};

	always_comb begin
		op      = '0;
		legal   = 1'b1;
		word    = 1'b0;
		sel_imm = 1'b0;
		sel_u   = 1'b0;
		sel_pc  = 1'b0;
		src1_zx = 1'b0;
		src1_sx = 1'b0;
		shamt5  = 1'b0;
		case (instr.r_fmt.opcode)
			rv64_exu_pkg::OPC_OP_IMM: begin
				sel_imm = 1'b1;
				case (instr.r_fmt.funct3)
					rv64_exu_pkg::F3_ADD_SUB: op[rv64_exu_pkg::OP_ADD]  = 1'b1;
					rv64_exu_pkg::F3_SLT:     op[rv64_exu_pkg::OP_SLT]  = 1'b1;
					rv64_exu_pkg::F3_SLTU:    op[rv64_exu_pkg::OP_SLTU] = 1'b1;
					rv64_exu_pkg::F3_XOR:     op[rv64_exu_pkg::OP_XOR]  = 1'b1;
					rv64_exu_pkg::F3_OR:      op[rv64_exu_pkg::OP_OR]   = 1'b1;
					rv64_exu_pkg::F3_AND:     op[rv64_exu_pkg::OP_AND]  = 1'b1;
					rv64_exu_pkg::F3_SLL: begin
						// funct6 only, bit 25 belongs to the shift amount
						if (instr.r_fmt.funct7[6:1] == rv64_exu_pkg::F7_BASE[6:1])
							op[rv64_exu_pkg::OP_SLL] = 1'b1;
						else
							legal = 1'b0;
					end
					default: begin // srli / srai
						if (instr.r_fmt.funct7[6:1] == rv64_exu_pkg::F7_BASE[6:1])
							op[rv64_exu_pkg::OP_SRL] = 1'b1;
						else if (instr.r_fmt.funct7[6:1] == rv64_exu_pkg::F7_ALT[6:1])
							op[rv64_exu_pkg::OP_SRA] = 1'b1;
						else
							legal = 1'b0;
					end
				endcase
			end
			rv64_exu_pkg::OPC_OP: begin
				if (instr.r_fmt.funct7 == rv64_exu_pkg::F7_MULDIV) begin
					case (instr.r_fmt.funct3)
						rv64_exu_pkg::F3_MUL:  op[rv64_exu_pkg::OP_MUL] = 1'b1;
						rv64_exu_pkg::F3_DIVU: op[rv64_exu_pkg::OP_DIV] = 1'b1;
						rv64_exu_pkg::F3_REMU: op[rv64_exu_pkg::OP_REM] = 1'b1;
						default:               legal = 1'b0; // mulh, signed div/rem
					endcase
				end else if (instr.r_fmt.funct7 == rv64_exu_pkg::F7_ALT) begin
					case (instr.r_fmt.funct3)
						rv64_exu_pkg::F3_ADD_SUB: op[rv64_exu_pkg::OP_SUB] = 1'b1;
						rv64_exu_pkg::F3_SRL_SRA: op[rv64_exu_pkg::OP_SRA] = 1'b1;
						default:                  legal = 1'b0;
					endcase
				end else if (instr.r_fmt.funct7 == rv64_exu_pkg::F7_BASE) begin
					case (instr.r_fmt.funct3)
						rv64_exu_pkg::F3_ADD_SUB: op[rv64_exu_pkg::OP_ADD]  = 1'b1;
						rv64_exu_pkg::F3_SLL:     op[rv64_exu_pkg::OP_SLL]  = 1'b1;
						rv64_exu_pkg::F3_SLT:     op[rv64_exu_pkg::OP_SLT]  = 1'b1;
						rv64_exu_pkg::F3_SLTU:    op[rv64_exu_pkg::OP_SLTU] = 1'b1;
						rv64_exu_pkg::F3_XOR:     op[rv64_exu_pkg::OP_XOR]  = 1'b1;
						rv64_exu_pkg::F3_SRL_SRA: op[rv64_exu_pkg::OP_SRL]  = 1'b1;
						rv64_exu_pkg::F3_OR:      op[rv64_exu_pkg::OP_OR]   = 1'b1;
						default:                  op[rv64_exu_pkg::OP_AND]  = 1'b1;
					endcase
				end else begin
					legal = 1'b0;
				end
			end
			rv64_exu_pkg::OPC_OP_IMM_32, rv64_exu_pkg::OPC_OP_32: begin
				word    = 1'b1;
				sel_imm = (instr.r_fmt.opcode == rv64_exu_pkg::OPC_OP_IMM_32);
				case (instr.r_fmt.funct3)
					rv64_exu_pkg::F3_ADD_SUB: begin
						if (sel_imm || instr.r_fmt.funct7 == rv64_exu_pkg::F7_BASE)
							op[rv64_exu_pkg::OP_ADD] = 1'b1; // addiw ignores funct7
						else if (instr.r_fmt.funct7 == rv64_exu_pkg::F7_ALT)
							op[rv64_exu_pkg::OP_SUB] = 1'b1;
						else
							legal = 1'b0;
					end
					rv64_exu_pkg::F3_SLL: begin
						shamt5 = 1'b1;
						if (instr.r_fmt.funct7 == rv64_exu_pkg::F7_BASE)
							op[rv64_exu_pkg::OP_SLL] = 1'b1;
						else
							legal = 1'b0;
					end
					rv64_exu_pkg::F3_SRL_SRA: begin
						shamt5 = 1'b1;
						if (instr.r_fmt.funct7 == rv64_exu_pkg::F7_BASE) begin
							op[rv64_exu_pkg::OP_SRL] = 1'b1;
							src1_zx = 1'b1;
						end else if (instr.r_fmt.funct7 == rv64_exu_pkg::F7_ALT) begin
							op[rv64_exu_pkg::OP_SRA] = 1'b1;
							src1_sx = 1'b1;
						end else begin
							legal = 1'b0;
						end
					end
					default: legal = 1'b0;
				endcase
			end
			rv64_exu_pkg::OPC_LUI: begin
				sel_imm = 1'b1;
				sel_u   = 1'b1;
				op[rv64_exu_pkg::OP_LUI] = 1'b1;
			end
			rv64_exu_pkg::OPC_AUIPC: begin
				sel_imm = 1'b1;
				sel_u   = 1'b1;
				sel_pc  = 1'b1;
				op[rv64_exu_pkg::OP_ADD] = 1'b1; // pc + imm
			end
			default: legal = 1'b0;
		endcase
	end

	assign op_a = sel_pc ? in_pc : in_rs1;
	assign op_b = sel_imm ? (sel_u ? imm_u : imm_i) : in_rs2;

	assign req.valid       = in_valid & legal;
	assign req.alu_control = legal ? op : '0;
	assign req.word_op     = word;
	assign req.rd          = instr.r_fmt.rd;
	assign req.src1 = src1_zx ? {{(XLEN-32){1'b0}}, op_a[31:0]} :
		src1_sx ? {{(XLEN-32){op_a[31]}}, op_a[31:0]} : op_a;
	assign req.src2 = shamt5 ? {{(XLEN-5){1'b0}}, op_b[4:0]} : op_b;

endmodule

// File: design/alu_req_if.sv
// decoded ALU request
`timescale 1ns/1ps

interface alu_req_if;

	logic                                valid;       // one-cycle strobe
	logic [rv64_exu_pkg::ALU_OPS-1:0]    alu_control; // one-hot
	logic [rv64_exu_pkg::XLEN-1:0]       src1;
	logic [rv64_exu_pkg::XLEN-1:0]       src2;
	logic                                word_op;     // W form, result is sign-extended
	logic [4:0]                          rd;

	modport producer (
		output valid, alu_control, src1, src2, word_op, rd
	);

	modport consumer (
		input valid, alu_control, src1, src2, word_op, rd
	);

endinterface

// File: design/rv64_exu_pkg.sv
// RV64 execute stage definitions
package rv64_exu_pkg;

	localparam int XLEN    = 64;
	localparam int ALU_OPS = 14;

	// one-hot control bit positions
	localparam int OP_ADD  = 0;
	localparam int OP_SUB  = 1;
	localparam int OP_SLT  = 2;
	localparam int OP_SLTU = 3;
	localparam int OP_AND  = 4;
	localparam int OP_OR   = 5;
	localparam int OP_XOR  = 6;
	localparam int OP_SLL  = 7;
	localparam int OP_SRL  = 8;
	localparam int OP_SRA  = 9;
	localparam int OP_LUI  = 10;
	localparam int OP_MUL  = 11;
	localparam int OP_DIV  = 12;
	localparam int OP_REM  = 13;

	// major opcodes
	localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
	localparam logic [6:0] OPC_OP        = 7'b0110011;
	localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
	localparam logic [6:0] OPC_OP_32     = 7'b0111011;
	localparam logic [6:0] OPC_LUI       = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

	localparam logic [2:0] F3_ADD_SUB = 3'b000;
	localparam logic [2:0] F3_SLL     = 3'b001;
	localparam logic [2:0] F3_SLT     = 3'b010;
	localparam logic [2:0] F3_SLTU    = 3'b011;
	localparam logic [2:0] F3_XOR     = 3'b100;
	localparam logic [2:0] F3_SRL_SRA = 3'b101;
	localparam logic [2:0] F3_OR      = 3'b110;
	localparam logic [2:0] F3_AND     = 3'b111;
	localparam logic [2:0] F3_MUL     = 3'b000; // M extension, funct7 = F7_MULDIV
	localparam logic [2:0] F3_DIVU    = 3'b101;
	localparam logic [2:0] F3_REMU    = 3'b111;

	localparam logic [6:0] F7_BASE   = 7'b0000000;
	localparam logic [6:0] F7_ALT    = 7'b0100000; // sub, sra
	localparam logic [6:0] F7_MULDIV = 7'b0000001;

	typedef union packed {
		struct packed {
			logic [6:0] funct7;
			logic [4:0] rs2;
			logic [4:0] rs1;
			logic [2:0] funct3;
			logic [4:0] rd;
			logic [6:0] opcode;
		} r_fmt;
		struct packed {
			logic [11:0] imm12;
			logic [4:0]  rs1;
			logic [2:0]  funct3;
			logic [4:0]  rd;
			logic [6:0]  opcode;
		} i_fmt;
	} rv64_instr_u;

endpackage
